// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // The core starts with one credit per queue entry.
    localparam int queue_depth = 4;
    localparam int queue_ptr_width = $clog2(queue_depth);
    localparam int queue_count_width = $clog2(queue_depth + 1);

    // Access size is log2 of the byte count.
    typedef logic [1:0] size_t;

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;
    localparam size_t size_bad = 2'd3;

    localparam int max_size = 2; // Largest legal size_t.

    // Function code from the core. The low bits carry the size.
    localparam int funct_width = 3;
    localparam int funct_unsigned_bit = 2; // Set for zero extension on loads.

endpackage

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int data_width = 32;
    localparam int byte_width = 8;
    localparam int bytes_per_word = data_width / byte_width;

    // The RAM is word addressed. The core addresses bytes.
    localparam int ram_words = 64;
    localparam int word_addr_width = $clog2(ram_words);
    localparam int lane_bits = $clog2(bytes_per_word);
    localparam int byte_addr_width = word_addr_width + lane_bits;

endpackage

`default_nettype wire

// ==== rtl/lsu_decode.sv ====
`default_nettype none
`timescale 1ns/10ps

module lsu_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  logic                                req_store,
    input  logic [lsu_pkg::funct_width-1:0]     req_funct,
    input  logic [mem_pkg::byte_addr_width-1:0] req_addr,
    input  logic [mem_pkg::data_width-1:0]      req_wdata,
    input  logic                                pop,
    output logic                                head_valid,
    output logic                                head_store,
    output logic                                head_unsigned,
    output lsu_pkg::size_t                      head_size,
    output logic [mem_pkg::byte_addr_width-1:0] head_addr,
    output logic [mem_pkg::data_width-1:0]      head_wdata,
    output logic                                credit_return
);

    logic                                q_store    [lsu_pkg::queue_depth];
    logic                                q_unsigned [lsu_pkg::queue_depth];
    lsu_pkg::size_t                      q_size     [lsu_pkg::queue_depth];
    logic [mem_pkg::byte_addr_width-1:0] q_addr     [lsu_pkg::queue_depth];
    logic [mem_pkg::data_width-1:0]      q_wdata    [lsu_pkg::queue_depth];

    logic [lsu_pkg::queue_ptr_width-1:0]   wr_ptr;
    logic [lsu_pkg::queue_ptr_width-1:0]   rd_ptr;
    logic [lsu_pkg::queue_count_width-1:0] count;

    localparam logic [lsu_pkg::queue_ptr_width-1:0] last_ptr =
        lsu_pkg::queue_ptr_width'(lsu_pkg::queue_depth - 1);

    // Entries are stored already split into signedness and size.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_store[wr_ptr]    <= req_store;
            q_unsigned[wr_ptr] <= req_funct[lsu_pkg::funct_unsigned_bit];
            q_size[wr_ptr]     <= lsu_pkg::size_t'(req_funct[lsu_pkg::funct_unsigned_bit-1:0]);
            q_addr[wr_ptr]     <= req_addr;
            q_wdata[wr_ptr]    <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Push and pop together leave it level.
            endcase
        end
    end

    assign head_valid    = count != '0;
    assign head_store    = q_store[rd_ptr];
    assign head_unsigned = q_unsigned[rd_ptr];
    assign head_size     = q_size[rd_ptr];
    assign head_addr     = q_addr[rd_ptr];
    assign head_wdata    = q_wdata[rd_ptr];

    // Every entry that leaves hands one credit back to the core.
    assign credit_return = pop;

endmodule

`default_nettype wire

// ==== rtl/lsu_execute.sv ====
`default_nettype none
`timescale 1ns/10ps

module lsu_execute (
    input  logic                                head_valid,
    input  logic                                head_store,
    input  logic                                head_unsigned,
    input  lsu_pkg::size_t                      head_size,
    input  logic [mem_pkg::byte_addr_width-1:0] head_addr,
    input  logic [mem_pkg::data_width-1:0]      head_wdata,
    input  logic                                load_busy,
    output logic                                pop,
    output logic                                store_done,
    output logic                                malign_done,
    output logic                                load_issue,
    output logic                                load_unsigned,
    output lsu_pkg::size_t                      load_size,
    output logic [mem_pkg::lane_bits-1:0]       load_offset,
    output logic                                ram_read,
    output logic                                ram_write,
    output logic [mem_pkg::word_addr_width-1:0] ram_addr,
    output logic [mem_pkg::bytes_per_word-1:0]  ram_be,
    output logic [mem_pkg::data_width-1:0]      ram_wdata
);

    logic [mem_pkg::lane_bits-1:0] offset;
    logic [mem_pkg::lane_bits-1:0] align_mask;
    logic [mem_pkg::lane_bits:0]   end_lane;
    logic                          size_invalid;
    logic                          malign;

    assign offset = head_addr[mem_pkg::lane_bits-1:0];

    // Low address bits that must be clear for the access size.
    assign align_mask   = mem_pkg::lane_bits'((1 << head_size) - 1);
    assign size_invalid = int'(head_size) > lsu_pkg::max_size;
    assign malign       = size_invalid || ((offset & align_mask) != '0);

    // Last lane touched is the offset plus the byte count minus one.
    assign end_lane = {1'b0, offset} + {1'b0, align_mask};

    always_comb begin
        for (int j = 0; j < mem_pkg::bytes_per_word; j++) begin
            ram_be[j] = (j >= int'(offset)) && (j <= int'(end_lane));
        end
    end

    assign ram_wdata = head_wdata << (offset * mem_pkg::byte_width);
    assign ram_addr  = head_addr[mem_pkg::byte_addr_width-1:mem_pkg::lane_bits];

    // The pop after a load waits one cycle for the response to go out.
    assign pop         = head_valid && !load_busy;
    assign malign_done = pop && malign;
    assign store_done  = pop && head_store && !malign;
    assign load_issue  = pop && !head_store && !malign;

    assign ram_read  = load_issue;
    assign ram_write = store_done;

    assign load_unsigned = head_unsigned;
    assign load_size     = head_size;
    assign load_offset   = offset;

endmodule

`default_nettype wire

// ==== rtl/lsu_result.sv ====
`default_nettype none
`timescale 1ns/10ps

module lsu_result (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_issue,
    input  logic                          store_done,
    input  logic                          malign_done,
    input  logic                          load_unsigned,
    input  lsu_pkg::size_t                load_size,
    input  logic [mem_pkg::lane_bits-1:0] load_offset,
    input  logic [mem_pkg::data_width-1:0] ram_rdata,
    output logic                          load_busy,
    output logic                          resp_valid,
    output logic                          resp_malign,
    output logic [mem_pkg::data_width-1:0] resp_data
);

    localparam int half_width = 2 * mem_pkg::byte_width;

    logic                           pend_unsigned;
    lsu_pkg::size_t                 pend_size;
    logic [mem_pkg::lane_bits-1:0]  pend_offset;
    logic [mem_pkg::data_width-1:0] shifted;
    logic [mem_pkg::data_width-1:0] extended;
    logic                           sign;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_busy <= 1'b0;
        end else begin
            load_busy <= load_issue; // High while the RAM word is on its way back.
        end
    end

    always_ff @(posedge clk) begin
        pend_unsigned <= load_unsigned;
        pend_size     <= load_size;
        pend_offset   <= load_offset;
    end

    assign shifted = ram_rdata >> (pend_offset * mem_pkg::byte_width);

    always_comb begin
        sign = 1'b0;
        case (pend_size)
            lsu_pkg::size_byte: begin
                sign     = !pend_unsigned && shifted[mem_pkg::byte_width-1];
                extended = {{(mem_pkg::data_width - mem_pkg::byte_width){sign}},
                            shifted[mem_pkg::byte_width-1:0]};
            end
            lsu_pkg::size_half: begin
                sign     = !pend_unsigned && shifted[half_width-1];
                extended = {{(mem_pkg::data_width - half_width){sign}},
                            shifted[half_width-1:0]};
            end
            lsu_pkg::size_word: extended = shifted;
            lsu_pkg::size_bad:  extended = '0; // Never issued to the RAM.
        endcase
    end

    // Stores and misaligned accesses answer with zero data.
    assign resp_valid  = load_busy || store_done || malign_done;
    assign resp_malign = malign_done;
    assign resp_data   = load_busy ? extended : '0;

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module data_ram (
    input  logic                                clk,
    input  logic                                ram_read,
    input  logic                                ram_write,
    input  logic [mem_pkg::word_addr_width-1:0] ram_addr,
    input  logic [mem_pkg::bytes_per_word-1:0]  ram_be,
    input  logic [mem_pkg::data_width-1:0]      ram_wdata,
    output logic [mem_pkg::data_width-1:0]      ram_rdata
);

    logic [mem_pkg::data_width-1:0] mem [mem_pkg::ram_words];

    // Only the enabled lanes of the word are written.
    always_ff @(posedge clk) begin
        if (ram_write) begin
            for (int i = 0; i < mem_pkg::bytes_per_word; i++) begin
                if (ram_be[i]) begin
                    mem[ram_addr][i*mem_pkg::byte_width +: mem_pkg::byte_width] <=
                        ram_wdata[i*mem_pkg::byte_width +: mem_pkg::byte_width];
                end
            end
        end
    end

    // Read data shows up one cycle after the request.
    always_ff @(posedge clk) begin
        if (ram_read) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module lsu_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  logic                                req_store,
    input  logic [lsu_pkg::funct_width-1:0]     req_funct,
    input  logic [mem_pkg::byte_addr_width-1:0] req_addr,
    input  logic [mem_pkg::data_width-1:0]      req_wdata,
    output logic                                credit_return,
    output logic                                resp_valid,
    output logic                                resp_malign,
    output logic [mem_pkg::data_width-1:0]      resp_data
);

    logic                                head_valid;
    logic                                head_store;
    logic                                head_unsigned;
    lsu_pkg::size_t                      head_size;
    logic [mem_pkg::byte_addr_width-1:0] head_addr;
    logic [mem_pkg::data_width-1:0]      head_wdata;
    logic                                pop;
    logic                                store_done;
    logic                                malign_done;
    logic                                load_issue;
    logic                                load_busy;
    logic                                load_unsigned;
    lsu_pkg::size_t                      load_size;
    logic [mem_pkg::lane_bits-1:0]       load_offset;
    logic                                ram_read;
    logic                                ram_write;
    logic [mem_pkg::word_addr_width-1:0] ram_addr;
    logic [mem_pkg::bytes_per_word-1:0]  ram_be;
    logic [mem_pkg::data_width-1:0]      ram_wdata;
    logic [mem_pkg::data_width-1:0]      ram_rdata;

    lsu_decode lsu_decode_i (
        .clk, .rst_n, .req_valid, .req_store, .req_funct, .req_addr, .req_wdata,
        .pop, .head_valid, .head_store, .head_unsigned, .head_size, .head_addr,
        .head_wdata, .credit_return
    );

    lsu_execute lsu_execute_i (
        .head_valid, .head_store, .head_unsigned, .head_size, .head_addr, .head_wdata,
        .load_busy, .pop, .store_done, .malign_done, .load_issue, .load_unsigned,
        .load_size, .load_offset, .ram_read, .ram_write, .ram_addr, .ram_be, .ram_wdata
    );

    lsu_result lsu_result_i (
        .clk, .rst_n, .load_issue, .store_done, .malign_done, .load_unsigned,
        .load_size, .load_offset, .ram_rdata, .load_busy, .resp_valid, .resp_malign,
        .resp_data
    );

    data_ram data_ram_i (
        .clk, .ram_read, .ram_write, .ram_addr, .ram_be, .ram_wdata, .ram_rdata
    );

endmodule

`default_nettype wire

// ==== test/tb_lsu.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_lsu;

    localparam int clk_period = 100;
    localparam int random_requests = 200;
    localparam int directed_requests = 64; // Upper bound on the hand-written cases.
    localparam int total_requests = mem_pkg::ram_words + directed_requests + random_requests;

    logic                                clk;
    logic                                rst_n;
    logic                                req_valid;
    logic                                req_store;
    logic [lsu_pkg::funct_width-1:0]     req_funct;
    logic [mem_pkg::byte_addr_width-1:0] req_addr;
    logic [mem_pkg::data_width-1:0]      req_wdata;
    logic                                credit_return;
    logic                                resp_valid;
    logic                                resp_malign;
    logic [mem_pkg::data_width-1:0]      resp_data;

    logic [mem_pkg::byte_width-1:0] ref_mem [2**mem_pkg::byte_addr_width];
    logic [mem_pkg::data_width-1:0] exp_data [$];
    logic                           exp_malign [$];
    logic [31:0]                    lfsr = 32'h2bfb7eda;
    int                             credits = lsu_pkg::queue_depth;
    int                             sent_count = 0;
    int                             returned_count = 0;

    lsu_top lsu_top_i (
        .clk, .rst_n, .req_valid, .req_store, .req_funct, .req_addr, .req_wdata,
        .credit_return, .resp_valid, .resp_malign, .resp_data
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic note_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic fail_because(input string what);
        $display("error at %0t: %s", $time, what);
        abort_run();
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Little-endian bytes from the model, extended by sign unless asked for zero.
    function automatic logic [31:0] expected_load(input logic [7:0] addr, input int nbytes,
                                                  input logic uns);
        logic [31:0] val;
        logic        sign;
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[i*8 +: 8] = ref_mem[int'(addr) + i];
        end
        sign = !uns && val[nbytes*8-1];
        for (int i = nbytes * 8; i < 32; i++) begin
            val[i] = sign;
        end
        return val;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_request(input logic store, input logic [2:0] funct,
                                input logic [7:0] addr, input logic [31:0] wdata);
        lsu_pkg::size_t size;
        int             nbytes;
        logic           malign;
        size   = funct[1:0];
        nbytes = 1 << size;
        malign = (size == lsu_pkg::size_bad) || ((int'(addr) % nbytes) != 0);
        while (credits == 0) begin
            idle_cycles(1);
        end
        if (malign) begin
            exp_data.push_back('0);
            exp_malign.push_back(1'b1);
        end else if (store) begin
            for (int i = 0; i < nbytes; i++) begin
                ref_mem[int'(addr) + i] = wdata[i*8 +: 8];
            end
            exp_data.push_back('0);
            exp_malign.push_back(1'b0);
        end else begin
            exp_data.push_back(expected_load(addr, nbytes, funct[2]));
            exp_malign.push_back(1'b0);
        end
        req_valid = 1'b1;
        req_store = store;
        req_funct = funct;
        req_addr  = addr;
        req_wdata = wdata;
        idle_cycles(1);
        req_valid = 1'b0;
        sent_count++;
    endtask

    // Every byte of the word, both halves and the word, each signed and unsigned.
    task automatic check_readback(input logic [7:0] base);
        for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 4; off++) begin
                send_request(1'b0, {1'(u), lsu_pkg::size_byte}, base + 8'(off), '0);
            end
            send_request(1'b0, {1'(u), lsu_pkg::size_half}, base, '0);
            send_request(1'b0, {1'(u), lsu_pkg::size_half}, base + 8'd2, '0);
            send_request(1'b0, {1'(u), lsu_pkg::size_word}, base, '0);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            credits <= credits - int'(req_valid) + int'(credit_return);
            if (credit_return) begin
                returned_count <= returned_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && resp_valid) begin
            assert (exp_data.size() > 0) else fail_because("response with nothing outstanding");
            assert (resp_malign == exp_malign[0])
                else note_mismatch("resp_malign", 32'(resp_malign), 32'(exp_malign[0]));
            assert (resp_data == exp_data[0])
                else note_mismatch("resp_data", resp_data, exp_data[0]);
            void'(exp_data.pop_front());
            void'(exp_malign.pop_front());
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        sent_count == 0 |-> !resp_valid && !credit_return)
        else fail_because("response side active before any request");

    assert property (@(posedge clk) disable iff (!rst_n)
        credits >= 0 && credits <= lsu_pkg::queue_depth)
        else fail_because("credit counter left its range");

    initial begin
        #((total_requests * 200 + 50) * clk_period);
        $display("timeout at %0t: responses did not drain", $time);
        abort_run();
    end

    initial begin
        logic [31:0] rnd;
        logic        store;
        logic [2:0]  funct;
        logic [7:0]  addr;
        $timeformat(-9, 0, " ns", 0);
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_funct = '0;
        req_addr  = '0;
        req_wdata = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        idle_cycles(3);

        // The RAM holds no reset value, so every word is written first.
        for (int w = 0; w < mem_pkg::ram_words; w++) begin
            random_bits(32, rnd);
            send_request(1'b1, {1'b0, lsu_pkg::size_word}, 8'(w * 4), rnd);
        end

        send_request(1'b1, {1'b0, lsu_pkg::size_byte}, 8'h41, 32'h1234_56a5);
        check_readback(8'h40);
        send_request(1'b1, {1'b0, lsu_pkg::size_half}, 8'h82, 32'h7777_8c3e);
        check_readback(8'h80);
        send_request(1'b1, {1'b0, lsu_pkg::size_word}, 8'hc0, 32'hf00d_7b81);
        check_readback(8'hc0);

        send_request(1'b1, {1'b0, lsu_pkg::size_half}, 8'h43, 32'h0000_ffff);
        send_request(1'b0, {1'b0, lsu_pkg::size_half}, 8'h45, '0);
        send_request(1'b1, {1'b0, lsu_pkg::size_word}, 8'h42, 32'hffff_ffff);
        send_request(1'b0, {1'b1, lsu_pkg::size_word}, 8'h81, '0);
        send_request(1'b1, {1'b0, lsu_pkg::size_bad}, 8'h40, 32'hffff_ffff);
        send_request(1'b0, {1'b0, lsu_pkg::size_bad}, 8'h44, '0);
        send_request(1'b0, {1'b0, lsu_pkg::size_word}, 8'h40, '0); // Still the old bytes.
        send_request(1'b0, {1'b0, lsu_pkg::size_word}, 8'h44, '0);

        for (int n = 0; n < random_requests; n++) begin
            random_bits(1, rnd);
            store = rnd[0];
            random_bits(3, rnd);
            funct = rnd[2:0];
            random_bits(8, rnd);
            addr = rnd[7:0];
            random_bits(1, rnd);
            if (rnd[0] && funct[1:0] != lsu_pkg::size_bad) begin
                addr = addr & ~8'((1 << funct[1:0]) - 1); // Aligned half of the time.
            end
            random_bits(32, rnd);
            send_request(store, funct, addr, rnd);
            random_bits(2, rnd);
            idle_cycles(int'(rnd[1:0]));
        end

        // Every credit comes back no later than its response.
        while (exp_data.size() != 0) begin
            idle_cycles(1);
        end
        assert (returned_count == sent_count)
            else note_mismatch("credit_return count", 32'(returned_count), 32'(sent_count));
        assert (credits == lsu_pkg::queue_depth)
            else note_mismatch("credits", 32'(credits), 32'(lsu_pkg::queue_depth));
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/lsu_pkg.sv
rtl/mem_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/lsu_result.sv
rtl/data_ram.sv
rtl/lsu_top.sv
test/tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_lsu
FILELIST  := tb.f
BUILD_DIR := obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulation output is shown and searched for the pass line.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
